/* logic/lcd_clock_pkg.sv */
// --------------------------------------
// lcd clock display package
// shared character, mode and sequencer
// types, LCD glyph codes and commands
// --------------------------------------
package lcd_clock_pkg;

    typedef logic [7:0] char_t;         // ascii or lcd glyph code
    typedef logic [5:0] mode_code_t;    // raw mode input
    typedef logic [4:0] char_index_t;   // screen position 0..31

    typedef enum mode_code_t {
        TIME_VIEW       = 6'b000000,
        TIME_EDIT       = 6'b010000,
        TIME_EDIT_HOUR  = 6'b010011,
        TIME_EDIT_MIN   = 6'b010101,
        TIME_EDIT_SEC   = 6'b010111,
        ALARM_VIEW      = 6'b100001,
        ALARM_EDIT      = 6'b110001,
        ALARM_EDIT_HOUR = 6'b110011,
        ALARM_EDIT_MIN  = 6'b110101,
        ALARM_EDIT_SEC  = 6'b110111
    } display_mode_t;

    typedef enum logic [2:0] {
        POWERUP,
        FUNCTION_SET,
        DISPLAY_ON,
        ENTRY_MODE,
        LINE1,
        LINE2,
        RETURN_HOME
    } seq_state_t;

    localparam char_t CHAR_SPACE = 8'h20;
    localparam char_t CHAR_COLON = 8'h3A;
    localparam char_t CHAR_A     = 8'h41;
    localparam char_t CHAR_P     = 8'h50;
    localparam char_t CHAR_M     = 8'h4D;

    localparam char_t GLYPH_BELL = 8'h98;   // rom glyph, alarm bell
    localparam char_t GLYPH_NOTE = 8'h91;   // rom glyph, music note
    localparam char_t GLYPH_EDIT = 8'hA9;   // rom glyph, edit marker

    localparam char_t CMD_FUNCTION_SET = 8'h3C;  // 8-bit bus, 2 lines
    localparam char_t CMD_DISPLAY_ON   = 8'h0C;  // display on, no cursor
    localparam char_t CMD_ENTRY_MODE   = 8'h06;  // increment, no shift
    localparam char_t CMD_RETURN_HOME  = 8'h02;
    localparam char_t CMD_LINE1_ADDR   = 8'h80;
    localparam char_t CMD_LINE2_ADDR   = 8'hC0;

    localparam int LINE_CHARS       = 16;
    localparam int LINE_SLOT_CYCLES = 18;   // address, 16 chars, pad

endpackage

/* logic/screen_composer.sv */
// --------------------------------------
// screen composer
// builds the 2x16 character buffer from
// the mode, time or alarm digits, the
// flags and the blink phase
// --------------------------------------
module screen_composer (
    input  logic                       CLK,
    input  logic                       RESETN,
    input  lcd_clock_pkg::mode_code_t  mode,
    input  lcd_clock_pkg::char_t       hour_tens,
    input  lcd_clock_pkg::char_t       hour_units,
    input  lcd_clock_pkg::char_t       min_tens,
    input  lcd_clock_pkg::char_t       min_units,
    input  lcd_clock_pkg::char_t       sec_tens,
    input  lcd_clock_pkg::char_t       sec_units,
    input  lcd_clock_pkg::char_t       alarm_hour_tens,
    input  lcd_clock_pkg::char_t       alarm_hour_units,
    input  lcd_clock_pkg::char_t       alarm_min_tens,
    input  lcd_clock_pkg::char_t       alarm_min_units,
    input  lcd_clock_pkg::char_t       alarm_sec_tens,
    input  lcd_clock_pkg::char_t       alarm_sec_units,
    input  logic                       twelve_hour,
    input  logic                       alarm_enabled,
    input  logic                       alarm_ringing,
    input  logic                       blink_hidden,
    input  lcd_clock_pkg::char_index_t char_index,
    output logic                       blink_run,
    output lcd_clock_pkg::char_t       screen_char
);

    localparam int SCREEN_CHARS = 2 * lcd_clock_pkg::LINE_CHARS;

    lcd_clock_pkg::display_mode_t disp_mode;
    logic                         known_mode;
    logic                         alarm_side;
    logic                         edit_view;
    logic                         edit_hour;
    logic                         edit_min;
    logic                         edit_sec;
    lcd_clock_pkg::char_t         h10, h1, m10, m1, s10, s1;
    logic [6:0]                   hour_value;
    logic                         pm;
    lcd_clock_pkg::char_t         next_screen [SCREEN_CHARS];
    lcd_clock_pkg::char_t         screen_buf  [SCREEN_CHARS];

    assign disp_mode = lcd_clock_pkg::display_mode_t'(mode);

    always_comb
    begin
        known_mode = 1'b1;
        edit_view  = 1'b0;
        edit_hour  = 1'b0;
        edit_min   = 1'b0;
        edit_sec   = 1'b0;
        case (disp_mode)
            lcd_clock_pkg::TIME_VIEW,
            lcd_clock_pkg::ALARM_VIEW:      known_mode = 1'b1;
            lcd_clock_pkg::TIME_EDIT,
            lcd_clock_pkg::ALARM_EDIT:      edit_view = 1'b1;
            lcd_clock_pkg::TIME_EDIT_HOUR,
            lcd_clock_pkg::ALARM_EDIT_HOUR:
            begin
                edit_view = 1'b1;
                edit_hour = 1'b1;
            end
            lcd_clock_pkg::TIME_EDIT_MIN,
            lcd_clock_pkg::ALARM_EDIT_MIN:
            begin
                edit_view = 1'b1;
                edit_min  = 1'b1;
            end
            lcd_clock_pkg::TIME_EDIT_SEC,
            lcd_clock_pkg::ALARM_EDIT_SEC:
            begin
                edit_view = 1'b1;
                edit_sec  = 1'b1;
            end
            default:                        known_mode = 1'b0;  // blank screen
        endcase
    end

    assign alarm_side = mode[5];    // all alarm codes share the top bit
    assign blink_run  = edit_hour | edit_min | edit_sec;

    assign h10 = alarm_side ? alarm_hour_tens  : hour_tens;
    assign h1  = alarm_side ? alarm_hour_units : hour_units;
    assign m10 = alarm_side ? alarm_min_tens   : min_tens;
    assign m1  = alarm_side ? alarm_min_units  : min_units;
    assign s10 = alarm_side ? alarm_sec_tens   : sec_tens;
    assign s1  = alarm_side ? alarm_sec_units  : sec_units;

    // ascii digit low nibble is its value
    assign hour_value = 7'(h10[3:0]) * 7'd10 + 7'(h1[3:0]);
    assign pm         = (hour_value >= 7'd12);

    always_comb
    begin
        for (int i = 0; i < SCREEN_CHARS; i++)
            next_screen[i] = lcd_clock_pkg::CHAR_SPACE;
        if (known_mode)
        begin
            next_screen[1] = (edit_hour && blink_hidden) ? lcd_clock_pkg::CHAR_SPACE : h10;
            next_screen[2] = (edit_hour && blink_hidden) ? lcd_clock_pkg::CHAR_SPACE : h1;
            next_screen[3] = lcd_clock_pkg::CHAR_COLON;
            next_screen[4] = (edit_min && blink_hidden) ? lcd_clock_pkg::CHAR_SPACE : m10;
            next_screen[5] = (edit_min && blink_hidden) ? lcd_clock_pkg::CHAR_SPACE : m1;
            next_screen[6] = lcd_clock_pkg::CHAR_COLON;
            next_screen[7] = (edit_sec && blink_hidden) ? lcd_clock_pkg::CHAR_SPACE : s10;
            next_screen[8] = (edit_sec && blink_hidden) ? lcd_clock_pkg::CHAR_SPACE : s1;
            if (twelve_hour)
            begin
                next_screen[10] = pm ? lcd_clock_pkg::CHAR_P : lcd_clock_pkg::CHAR_A;
                next_screen[11] = lcd_clock_pkg::CHAR_M;
            end
            if (alarm_side)
                next_screen[13] = lcd_clock_pkg::GLYPH_BELL;
            if (edit_view)
                next_screen[14] = lcd_clock_pkg::GLYPH_EDIT;
            if (alarm_ringing)
                next_screen[29] = lcd_clock_pkg::GLYPH_NOTE;  // line 2
            if (alarm_enabled)
                next_screen[30] = lcd_clock_pkg::GLYPH_BELL;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (!RESETN)
        begin
            for (int i = 0; i < SCREEN_CHARS; i++)
                screen_buf[i] <= lcd_clock_pkg::CHAR_SPACE;
        end
        else
            screen_buf <= next_screen;
    end

    assign screen_char = screen_buf[char_index];    // read port for the sequencer

endmodule

/* logic/blink_timer.sv */
// --------------------------------------
// blink timer
// toggles the hidden phase of an edited
// field, up to a fixed number of toggles
// --------------------------------------
module blink_timer #(
    parameter int BLINK_HALF_CYCLES = 500,
    parameter int BLINK_TOGGLES     = 20
) (
    input  logic CLK,
    input  logic RESETN,
    input  logic blink_run,
    output logic blink_hidden
);

    localparam int CYCLE_W  = $clog2(BLINK_HALF_CYCLES + 1);
    localparam int TOGGLE_W = $clog2(BLINK_TOGGLES + 1);

    logic [CYCLE_W-1:0]  cycle_cnt;
    logic [TOGGLE_W-1:0] toggle_cnt;

    always_ff @(posedge CLK)
    begin
        if (!RESETN || !blink_run)
        begin
            cycle_cnt    <= '0;
            toggle_cnt   <= '0;
            blink_hidden <= 1'b0;
        end
        else if (toggle_cnt != TOGGLE_W'(BLINK_TOGGLES))    // still blinking
        begin
            if (cycle_cnt == CYCLE_W'(BLINK_HALF_CYCLES - 1))
            begin
                cycle_cnt    <= '0;
                toggle_cnt   <= toggle_cnt + 1'b1;
                // last toggle always leaves the field shown
                blink_hidden <= (toggle_cnt == TOGGLE_W'(BLINK_TOGGLES - 1)) ? 1'b0
                                                                           : ~blink_hidden;
            end
            else
                cycle_cnt <= cycle_cnt + 1'b1;
        end
    end

endmodule

/* logic/lcd_sequencer.sv */
// --------------------------------------
// lcd sequencer
// power-up wait, init commands, then a
// line 1 / line 2 / return home refresh
// loop, one bus byte per cycle
// --------------------------------------
module lcd_sequencer #(
    parameter int POWERUP_CYCLES = 71,
    parameter int CMD_CYCLES     = 31
) (
    input  logic                       CLK,
    input  logic                       RESETN,
    input  lcd_clock_pkg::char_t       screen_char,
    output lcd_clock_pkg::char_index_t char_index,
    output logic                       lcd_e,
    output logic                       lcd_rs,
    output logic                       lcd_rw,
    output lcd_clock_pkg::char_t       lcd_data
);

    localparam int LONGEST_WAIT = (POWERUP_CYCLES > CMD_CYCLES) ? POWERUP_CYCLES : CMD_CYCLES;
    localparam int LONGEST_SLOT = (LONGEST_WAIT > lcd_clock_pkg::LINE_SLOT_CYCLES)
                                  ? LONGEST_WAIT : lcd_clock_pkg::LINE_SLOT_CYCLES;
    localparam int COUNT_W      = $clog2(LONGEST_SLOT);

    lcd_clock_pkg::seq_state_t state, next_state;
    logic [COUNT_W-1:0]        slot_cnt;
    logic [COUNT_W-1:0]        slot_last;
    logic                      slot_done;
    logic [3:0]                char_offset;

    always_comb
    begin
        case (state)
            lcd_clock_pkg::POWERUP:      slot_last = COUNT_W'(POWERUP_CYCLES - 1);
            lcd_clock_pkg::FUNCTION_SET,
            lcd_clock_pkg::DISPLAY_ON,
            lcd_clock_pkg::ENTRY_MODE:   slot_last = COUNT_W'(CMD_CYCLES - 1);
            default:                     slot_last = COUNT_W'(lcd_clock_pkg::LINE_SLOT_CYCLES - 1);
        endcase
    end

    assign slot_done = (slot_cnt == slot_last);

    always_comb
    begin
        next_state = state;
        if (slot_done)
        begin
            case (state)
                lcd_clock_pkg::POWERUP:      next_state = lcd_clock_pkg::FUNCTION_SET;
                lcd_clock_pkg::FUNCTION_SET: next_state = lcd_clock_pkg::DISPLAY_ON;
                lcd_clock_pkg::DISPLAY_ON:   next_state = lcd_clock_pkg::ENTRY_MODE;
                lcd_clock_pkg::ENTRY_MODE:   next_state = lcd_clock_pkg::LINE1;
                lcd_clock_pkg::LINE1:        next_state = lcd_clock_pkg::LINE2;
                lcd_clock_pkg::LINE2:        next_state = lcd_clock_pkg::RETURN_HOME;
                lcd_clock_pkg::RETURN_HOME:  next_state = lcd_clock_pkg::LINE1;
                default:                     next_state = lcd_clock_pkg::POWERUP;
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (!RESETN)
        begin
            state    <= lcd_clock_pkg::POWERUP;
            slot_cnt <= '0;
        end
        else
        begin
            state    <= next_state;
            slot_cnt <= slot_done ? '0 : slot_cnt + 1'b1;
        end
    end

    // slot cycles 1..16 carry characters 0..15 of the line
    assign char_offset = slot_cnt[3:0] - 4'd1;
    assign char_index  = {state == lcd_clock_pkg::LINE2, char_offset};

    always_ff @(posedge CLK)
    begin
        if (!RESETN)
        begin
            lcd_e    <= 1'b0;
            lcd_rs   <= 1'b1;
            lcd_rw   <= 1'b1;
            lcd_data <= '0;
        end
        else
        begin
            lcd_e  <= (state != lcd_clock_pkg::POWERUP);
            lcd_rw <= (state == lcd_clock_pkg::POWERUP);
            lcd_rs <= 1'b0;
            case (state)
                lcd_clock_pkg::FUNCTION_SET: lcd_data <= lcd_clock_pkg::CMD_FUNCTION_SET;
                lcd_clock_pkg::DISPLAY_ON:   lcd_data <= lcd_clock_pkg::CMD_DISPLAY_ON;
                lcd_clock_pkg::ENTRY_MODE:   lcd_data <= lcd_clock_pkg::CMD_ENTRY_MODE;
                lcd_clock_pkg::RETURN_HOME:  lcd_data <= lcd_clock_pkg::CMD_RETURN_HOME;
                lcd_clock_pkg::LINE1,
                lcd_clock_pkg::LINE2:
                begin
                    if (slot_cnt == '0)
                        lcd_data <= (state == lcd_clock_pkg::LINE2) ? lcd_clock_pkg::CMD_LINE2_ADDR
                                                                    : lcd_clock_pkg::CMD_LINE1_ADDR;
                    else if (slot_cnt <= COUNT_W'(lcd_clock_pkg::LINE_CHARS))
                    begin
                        lcd_rs   <= 1'b1;
                        lcd_data <= screen_char;
                    end
                    else
                    begin
                        lcd_rs   <= 1'b1;
                        lcd_data <= lcd_clock_pkg::CHAR_SPACE;  // pad byte
                    end
                end
                default:
                begin
                    lcd_rs   <= 1'b1;   // power-up idle bus
                    lcd_data <= '0;
                end
            endcase
        end
    end

endmodule

/* logic/lcd_clock_top.sv */
// --------------------------------------
// lcd clock display top level
// screen composer, blink timer and the
// LCD bus sequencer
// --------------------------------------
module lcd_clock_top #(
    parameter int POWERUP_CYCLES    = 71,
    parameter int CMD_CYCLES        = 31,
    parameter int BLINK_HALF_CYCLES = 500,
    parameter int BLINK_TOGGLES     = 20
) (
    input  logic                      CLK,
    input  logic                      RESETN,
    input  lcd_clock_pkg::mode_code_t mode,
    input  lcd_clock_pkg::char_t      hour_tens,
    input  lcd_clock_pkg::char_t      hour_units,
    input  lcd_clock_pkg::char_t      min_tens,
    input  lcd_clock_pkg::char_t      min_units,
    input  lcd_clock_pkg::char_t      sec_tens,
    input  lcd_clock_pkg::char_t      sec_units,
    input  lcd_clock_pkg::char_t      alarm_hour_tens,
    input  lcd_clock_pkg::char_t      alarm_hour_units,
    input  lcd_clock_pkg::char_t      alarm_min_tens,
    input  lcd_clock_pkg::char_t      alarm_min_units,
    input  lcd_clock_pkg::char_t      alarm_sec_tens,
    input  lcd_clock_pkg::char_t      alarm_sec_units,
    input  logic                      twelve_hour,
    input  logic                      alarm_enabled,
    input  logic                      alarm_ringing,
    output logic                      lcd_e,
    output logic                      lcd_rs,
    output logic                      lcd_rw,
    output lcd_clock_pkg::char_t      lcd_data
);

    logic                        blink_run;
    logic                        blink_hidden;
    lcd_clock_pkg::char_index_t  char_index;
    lcd_clock_pkg::char_t        screen_char;

    screen_composer u_screen_composer (
        .CLK              (CLK),
        .RESETN           (RESETN),
        .mode             (mode),
        .hour_tens        (hour_tens),
        .hour_units       (hour_units),
        .min_tens         (min_tens),
        .min_units        (min_units),
        .sec_tens         (sec_tens),
        .sec_units        (sec_units),
        .alarm_hour_tens  (alarm_hour_tens),
        .alarm_hour_units (alarm_hour_units),
        .alarm_min_tens   (alarm_min_tens),
        .alarm_min_units  (alarm_min_units),
        .alarm_sec_tens   (alarm_sec_tens),
        .alarm_sec_units  (alarm_sec_units),
        .twelve_hour      (twelve_hour),
        .alarm_enabled    (alarm_enabled),
        .alarm_ringing    (alarm_ringing),
        .blink_hidden     (blink_hidden),
        .char_index       (char_index),
        .blink_run        (blink_run),
        .screen_char      (screen_char)
    );

    blink_timer #(
        .BLINK_HALF_CYCLES (BLINK_HALF_CYCLES),
        .BLINK_TOGGLES     (BLINK_TOGGLES)
    ) u_blink_timer (
        .CLK          (CLK),
        .RESETN       (RESETN),
        .blink_run    (blink_run),
        .blink_hidden (blink_hidden)
    );

    lcd_sequencer #(
        .POWERUP_CYCLES (POWERUP_CYCLES),
        .CMD_CYCLES     (CMD_CYCLES)
    ) u_lcd_sequencer (
        .CLK         (CLK),
        .RESETN      (RESETN),
        .screen_char (screen_char),
        .char_index  (char_index),
        .lcd_e       (lcd_e),
        .lcd_rs      (lcd_rs),
        .lcd_rw      (lcd_rw),
        .lcd_data    (lcd_data)
    );

endmodule

/* test/lcd_clock_assertions.sv */
// --------------------------------------
// lcd bus protocol assertions
// bound to the sequencer; enable, write
// direction and address/data order
// --------------------------------------
module lcd_clock_assertions (
    input logic                 CLK,
    input logic                 RESETN,
    input logic                 lcd_e,
    input logic                 lcd_rs,
    input logic                 lcd_rw,
    input lcd_clock_pkg::char_t lcd_data
);
    timeunit 1ns;
    timeprecision 1ps;

    int failures = 0;   // read by the testbench at the end

    logic addr_byte;

    assign addr_byte = lcd_e && !lcd_rs &&
                       (lcd_data == lcd_clock_pkg::CMD_LINE1_ADDR ||
                        lcd_data == lcd_clock_pkg::CMD_LINE2_ADDR);

    // once enabled, the bus stays enabled and write-only
    e_stays_high: assert property (@(posedge CLK) disable iff (!RESETN)
        $past(lcd_e) |-> lcd_e)
    else
    begin
        failures++;
        $error("lcd_e dropped after power-up");
    end

    rw_low: assert property (@(posedge CLK) disable iff (!RESETN)
        lcd_e |-> !lcd_rw)
    else
    begin
        failures++;
        $error("lcd_rw high while lcd_e is high");
    end

    addr_then_data: assert property (@(posedge CLK) disable iff (!RESETN)
        addr_byte |=> lcd_rs)
    else
    begin
        failures++;
        $error("address command not followed by a data byte");
    end

    data_known: assert property (@(posedge CLK) disable iff (!RESETN)
        !$isunknown(lcd_data))
    else
    begin
        failures++;
        $error("lcd_data unknown after reset");
    end

endmodule

bind lcd_sequencer lcd_clock_assertions u_bus_assertions (
    .CLK      (CLK),
    .RESETN   (RESETN),
    .lcd_e    (lcd_e),
    .lcd_rs   (lcd_rs),
    .lcd_rw   (lcd_rw),
    .lcd_data (lcd_data)
);

/* test/lcd_clock_tb.sv */
// --------------------------------------
// lcd clock display testbench
// directed tests of init order, views,
// meridian, blink and unknown modes with
// an LCD bus monitor
// --------------------------------------
module lcd_clock_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int POWERUP_CYCLES = 71;
    localparam int CMD_CYCLES     = 31;
    localparam int LINE1_AT       = POWERUP_CYCLES + 3 * CMD_CYCLES + 1;
    // init plus about 70 frames of 54 cycles, with a wide margin
    localparam int TIMEOUT_CYCLES = 12000;

    logic                      CLK = 1'b0;
    logic                      RESETN;
    lcd_clock_pkg::mode_code_t mode;
    lcd_clock_pkg::char_t      time_d [6];    // hour, min, sec tens and units
    lcd_clock_pkg::char_t      alarm_d [6];
    logic                      twelve_hour;
    logic                      alarm_enabled;
    logic                      alarm_ringing;
    logic                      lcd_e;
    logic                      lcd_rs;
    logic                      lcd_rw;
    lcd_clock_pkg::char_t      lcd_data;

    integer               seed = 31004;
    int                   checks = 0;
    int                   value_errors = 0;
    int                   other_errors = 0;
    int                   cycle_count = 0;
    int                   frame_count = 0;
    int                   cap_line = 0;       // 0 idle, 1 or 2 capturing
    int                   cap_idx = 0;
    lcd_clock_pkg::char_t line_cap [32];
    lcd_clock_pkg::char_t exp_scr [32];

    lcd_clock_top #(
        .POWERUP_CYCLES    (POWERUP_CYCLES),
        .CMD_CYCLES        (CMD_CYCLES),
        .BLINK_HALF_CYCLES (40),
        .BLINK_TOGGLES     (4)
    ) dut (
        .CLK              (CLK),
        .RESETN           (RESETN),
        .mode             (mode),
        .hour_tens        (time_d[0]),
        .hour_units       (time_d[1]),
        .min_tens         (time_d[2]),
        .min_units        (time_d[3]),
        .sec_tens         (time_d[4]),
        .sec_units        (time_d[5]),
        .alarm_hour_tens  (alarm_d[0]),
        .alarm_hour_units (alarm_d[1]),
        .alarm_min_tens   (alarm_d[2]),
        .alarm_min_units  (alarm_d[3]),
        .alarm_sec_tens   (alarm_d[4]),
        .alarm_sec_units  (alarm_d[5]),
        .twelve_hour      (twelve_hour),
        .alarm_enabled    (alarm_enabled),
        .alarm_ringing    (alarm_ringing),
        .lcd_e            (lcd_e),
        .lcd_rs           (lcd_rs),
        .lcd_rw           (lcd_rw),
        .lcd_data         (lcd_data)
    );

    always #5 CLK = ~CLK;

    always @(posedge CLK)
    begin
        cycle_count++;
        if (cycle_count == TIMEOUT_CYCLES)
        begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic check_char(input string name, input lcd_clock_pkg::char_t got,
                              input lcd_clock_pkg::char_t exp);
        checks++;
        if (got !== exp)
        begin
            value_errors++;
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input bit got, input bit exp);
        checks++;
        if (got !== exp)
        begin
            value_errors++;
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    // bus monitor, 16 data bytes after each line address, then the pad
    always @(negedge CLK)
    begin
        if (RESETN && lcd_e)
        begin
            if (!lcd_rs && lcd_data == lcd_clock_pkg::CMD_LINE1_ADDR)
            begin
                cap_line = 1;
                cap_idx  = 0;
            end
            else if (!lcd_rs && lcd_data == lcd_clock_pkg::CMD_LINE2_ADDR)
            begin
                cap_line = 2;
                cap_idx  = 0;
            end
            else if (lcd_rs && cap_line != 0 && cap_idx < lcd_clock_pkg::LINE_CHARS)
            begin
                line_cap[(cap_line - 1) * 16 + cap_idx] = lcd_data;
                cap_idx++;
                if (cap_line == 2 && cap_idx == lcd_clock_pkg::LINE_CHARS)
                    frame_count++;
            end
            else if (lcd_rs && cap_line != 0)
            begin
                check_char("lcd_data pad", lcd_data, lcd_clock_pkg::CHAR_SPACE);
                cap_line = 0;
            end
        end
    end

    task automatic wait_frames(input int n);
        int target;
        target = frame_count + n;
        wait (frame_count >= target);
    endtask

    function automatic lcd_clock_pkg::char_t random_digit();
        int value;
        value = $unsigned($random(seed)) % 10;
        return lcd_clock_pkg::char_t'(48 + value);
    endfunction

    task automatic randomize_digits();
        for (int i = 0; i < 6; i++)
        begin
            time_d[i]  = random_digit();
            alarm_d[i] = random_digit();
        end
    endtask

    task automatic set_hours(input bit alarm, input int h);
        if (alarm)
        begin
            alarm_d[0] = lcd_clock_pkg::char_t'(48 + h / 10);
            alarm_d[1] = lcd_clock_pkg::char_t'(48 + h % 10);
        end
        else
        begin
            time_d[0] = lcd_clock_pkg::char_t'(48 + h / 10);
            time_d[1] = lcd_clock_pkg::char_t'(48 + h % 10);
        end
    endtask

    task automatic fill_blank();
        for (int i = 0; i < 32; i++)
            exp_scr[i] = lcd_clock_pkg::CHAR_SPACE;
    endtask

    // reference screen from the layout rules
    task automatic build_expected(input bit alarm, input bit edit);
        lcd_clock_pkg::char_t d [6];
        int                   hours;
        for (int i = 0; i < 6; i++)
            d[i] = alarm ? alarm_d[i] : time_d[i];
        fill_blank();
        exp_scr[1] = d[0];
        exp_scr[2] = d[1];
        exp_scr[3] = lcd_clock_pkg::CHAR_COLON;
        exp_scr[4] = d[2];
        exp_scr[5] = d[3];
        exp_scr[6] = lcd_clock_pkg::CHAR_COLON;
        exp_scr[7] = d[4];
        exp_scr[8] = d[5];
        hours = (int'(d[0]) - 48) * 10 + (int'(d[1]) - 48);
        if (twelve_hour)
        begin
            exp_scr[10] = (hours >= 12) ? lcd_clock_pkg::CHAR_P : lcd_clock_pkg::CHAR_A;
            exp_scr[11] = lcd_clock_pkg::CHAR_M;
        end
        if (alarm)
            exp_scr[13] = lcd_clock_pkg::GLYPH_BELL;
        if (edit)
            exp_scr[14] = lcd_clock_pkg::GLYPH_EDIT;
        if (alarm_ringing)
            exp_scr[29] = lcd_clock_pkg::GLYPH_NOTE;
        if (alarm_enabled)
            exp_scr[30] = lcd_clock_pkg::GLYPH_BELL;
    endtask

    task automatic check_frame();
        for (int i = 0; i < 32; i++)
            check_char($sformatf("lcd_data line%0d[%0d]", i / 16 + 1, i % 16),
                       line_cap[i], exp_scr[i]);
    endtask

    // field may read as spaces, all else exact
    task automatic check_blink_frame(input int pos, output bit hidden, output bit shown);
        hidden = (line_cap[pos] == lcd_clock_pkg::CHAR_SPACE) &&
                 (line_cap[pos + 1] == lcd_clock_pkg::CHAR_SPACE);
        shown  = (line_cap[pos] == exp_scr[pos]) &&
                 (line_cap[pos + 1] == exp_scr[pos + 1]);
        for (int i = 0; i < 32; i++)
            if (!((i == pos || i == pos + 1) && line_cap[i] == lcd_clock_pkg::CHAR_SPACE))
                check_char($sformatf("lcd_data line%0d[%0d]", i / 16 + 1, i % 16),
                           line_cap[i], exp_scr[i]);
    endtask

    task automatic show_and_check(input lcd_clock_pkg::mode_code_t m, input bit alarm,
                                  input bit edit);
        @(negedge CLK);
        mode = m;
        wait_frames(2);     // first frame may be stale
        build_expected(alarm, edit);
        check_frame();
    endtask

    task automatic check_init();
        lcd_clock_pkg::char_t exp_data;
        bit                   exp_e;
        int                   phase;
        for (int c = 1; c <= LINE1_AT; c++)
        begin
            @(negedge CLK);
            exp_e = (c > POWERUP_CYCLES);
            phase = (c - POWERUP_CYCLES - 1) / CMD_CYCLES;
            if (!exp_e)
                exp_data = 8'h00;
            else if (c == LINE1_AT)
                exp_data = lcd_clock_pkg::CMD_LINE1_ADDR;
            else if (phase == 0)
                exp_data = lcd_clock_pkg::CMD_FUNCTION_SET;
            else if (phase == 1)
                exp_data = lcd_clock_pkg::CMD_DISPLAY_ON;
            else
                exp_data = lcd_clock_pkg::CMD_ENTRY_MODE;
            check_bit($sformatf("lcd_e cycle %0d", c), lcd_e, exp_e);
            check_bit($sformatf("lcd_rs cycle %0d", c), lcd_rs, !exp_e);
            check_bit($sformatf("lcd_rw cycle %0d", c), lcd_rw, !exp_e);
            check_char($sformatf("lcd_data cycle %0d", c), lcd_data, exp_data);
        end
    endtask

    task automatic test_time_view();
        randomize_digits();
        twelve_hour = 1'b0;
        for (int f = 0; f < 4; f++)
        begin
            alarm_enabled = f[0];
            alarm_ringing = f[1];
            show_and_check(lcd_clock_pkg::TIME_VIEW, 1'b0, 1'b0);
        end
    endtask

    task automatic test_meridian();
        twelve_hour = 1'b1;
        for (int side = 0; side < 2; side++)
            for (int h = 11; h <= 12; h++)
            begin
                set_hours(side == 1, h);
                set_hours(side == 0, 23 - h);   // other side reads the opposite half
                show_and_check((side == 1) ? lcd_clock_pkg::ALARM_VIEW
                                           : lcd_clock_pkg::TIME_VIEW, side == 1, 1'b0);
            end
    endtask

    task automatic test_alarm_edit_views();
        randomize_digits();
        twelve_hour   = 1'b0;
        alarm_enabled = 1'b1;
        alarm_ringing = 1'b0;
        show_and_check(lcd_clock_pkg::ALARM_VIEW, 1'b1, 1'b0);
        show_and_check(lcd_clock_pkg::TIME_EDIT, 1'b0, 1'b1);
        show_and_check(lcd_clock_pkg::ALARM_EDIT, 1'b1, 1'b1);
    endtask

    task automatic test_blink_mode(input lcd_clock_pkg::mode_code_t m, input bit alarm,
                                   input int pos);
        bit hidden;
        bit shown;
        bit saw_hidden;
        bit saw_shown;
        saw_hidden = 1'b0;
        saw_shown  = 1'b0;
        @(negedge CLK);
        mode = lcd_clock_pkg::TIME_VIEW;    // blink counts clear
        @(negedge CLK);
        mode = m;
        wait_frames(1);
        build_expected(alarm, 1'b1);
        repeat (4)
        begin
            wait_frames(1);
            check_blink_frame(pos, hidden, shown);
            saw_hidden |= hidden;
            saw_shown  |= shown;
        end
        if (!saw_hidden)
        begin
            other_errors++;
            $display("mode 0x%h: edited field at position %0d never blanked", m, pos);
        end
        if (!saw_shown)
        begin
            other_errors++;
            $display("mode 0x%h: edited field at position %0d never shown", m, pos);
        end
        repeat (2)
        begin
            wait_frames(1);     // toggles done, field stays
            check_frame();
        end
    endtask

    task automatic test_blink();
        randomize_digits();
        twelve_hour = 1'b1;
        test_blink_mode(lcd_clock_pkg::TIME_EDIT_HOUR, 1'b0, 1);
        test_blink_mode(lcd_clock_pkg::TIME_EDIT_MIN, 1'b0, 4);
        test_blink_mode(lcd_clock_pkg::TIME_EDIT_SEC, 1'b0, 7);
        test_blink_mode(lcd_clock_pkg::ALARM_EDIT_HOUR, 1'b1, 1);
        test_blink_mode(lcd_clock_pkg::ALARM_EDIT_MIN, 1'b1, 4);
        test_blink_mode(lcd_clock_pkg::ALARM_EDIT_SEC, 1'b1, 7);
    endtask

    task automatic test_unknown_mode();
        @(negedge CLK);
        alarm_enabled = 1'b1;
        alarm_ringing = 1'b1;
        mode          = 6'b000001;
        wait_frames(2);
        fill_blank();
        check_frame();
        show_and_check(lcd_clock_pkg::TIME_VIEW, 1'b0, 1'b0);
    endtask

    initial
    begin
        RESETN        = 1'b0;
        mode          = lcd_clock_pkg::TIME_VIEW;
        twelve_hour   = 1'b0;
        alarm_enabled = 1'b0;
        alarm_ringing = 1'b0;
        for (int i = 0; i < 6; i++)
        begin
            time_d[i]  = 8'h30;
            alarm_d[i] = 8'h30;
        end
        repeat (3) @(posedge CLK);
        @(negedge CLK);
        RESETN = 1'b1;
        check_init();
        test_time_view();
        test_meridian();
        test_alarm_edit_views();
        test_blink();
        test_unknown_mode();
        other_errors += dut.u_lcd_sequencer.u_bus_assertions.failures;
        $display("checks %0d, value errors %0d, other errors %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

/* lcd_clock.f */
logic/lcd_clock_pkg.sv
logic/screen_composer.sv
logic/blink_timer.sv
logic/lcd_sequencer.sv
logic/lcd_clock_top.sv
test/lcd_clock_assertions.sv
test/lcd_clock_tb.sv

/* Makefile */
VERILATOR := verilator
FLAGS     := --binary --timing --assert --timescale 1ns/1ps -j 0
LINT      := --lint-only -Wall --timing --timescale 1ns/1ps
TOP       := lcd_clock_tb
FILELIST  := lcd_clock.f

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Result: PASSED"

lint:
	$(VERILATOR) $(LINT) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
